// ==== rtl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	localparam int xlen = 64;

	typedef logic [4:0] reg_idx_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Major opcodes.
	// ~~~~~~~~~~~~~~~~~~~~
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	// ALU operation class, picked by the decoder.
	typedef enum logic [2:0] {
		alu_add    = 3'd0, // Address or plain add.
		alu_func   = 3'd1, // Use func3 and func7_5.
		alu_branch = 3'd2,
		alu_lui    = 3'd3,
		alu_auipc  = 3'd4,
		alu_link   = 3'd5  // pc + 4.
	} alu_op_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Branch conditions in func3.
	// ~~~~~~~~~~~~~~~~~~~~
	localparam logic [2:0] br_eq  = 3'b000;
	localparam logic [2:0] br_ne  = 3'b001;
	localparam logic [2:0] br_lt  = 3'b100;
	localparam logic [2:0] br_ge  = 3'b101;
	localparam logic [2:0] br_ltu = 3'b110;
	localparam logic [2:0] br_geu = 3'b111;

endpackage

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  logic [31:0]            instr,
	input  logic                   instr_valid,
	output rv_pkg::reg_idx_t       rs1,
	output rv_pkg::reg_idx_t       rs2,
	output rv_pkg::reg_idx_t       rd,
	output logic [rv_pkg::xlen-1:0] imm,
	output logic [2:0]             func3,
	output logic                   func7_5,
	output logic                   op5,
	output logic                   utype,
	output rv_pkg::alu_op_t        alu_op,
	output logic                   alu_src,
	output logic                   reg_write,
	output logic                   mem_to_reg,
	output logic                   branch,
	output logic                   jump,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic                   valid
);

	logic [6:0] opcode;

	assign opcode  = instr[6:0];
	assign rs1     = instr[19:15];
	assign rs2     = instr[24:20];
	assign rd      = instr[11:7];
	assign func3   = instr[14:12];
	assign func7_5 = instr[30];
	assign op5     = instr[5]; // Low for the immediate forms.

	// ~~~~~~~~~~~~~~~~~~~~
	// Immediate formats.
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (opcode)
			rv_pkg::op_store:
				imm = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
			rv_pkg::op_branch:
				imm = {{(rv_pkg::xlen-12){instr[31]}}, instr[7], instr[30:25],
					instr[11:8], 1'b0};
			rv_pkg::op_lui, rv_pkg::op_auipc:
				imm = {{(rv_pkg::xlen-32){instr[31]}}, instr[31:12], 12'b0};
			rv_pkg::op_jal:
				imm = {{(rv_pkg::xlen-20){instr[31]}}, instr[19:12], instr[20],
					instr[30:21], 1'b0};
			default:
				imm = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:20]}; // I-type.
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Control bits.
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		alu_op     = rv_pkg::alu_add;
		alu_src    = 1'b0;
		reg_write  = 1'b0;
		mem_to_reg = 1'b0;
		branch     = 1'b0;
		jump       = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		utype      = 1'b0;
		valid      = 1'b0;
		if (instr_valid) begin
			valid = 1'b1; // Cleared again below for unknown opcodes.
			case (opcode)
				rv_pkg::op_lui: begin
					alu_op    = rv_pkg::alu_lui;
					alu_src   = 1'b1;
					reg_write = 1'b1;
					utype     = 1'b1;
				end
				rv_pkg::op_auipc: begin
					alu_op    = rv_pkg::alu_auipc;
					alu_src   = 1'b1;
					reg_write = 1'b1;
					utype     = 1'b1;
				end
				rv_pkg::op_jal: begin
					alu_op    = rv_pkg::alu_link;
					reg_write = 1'b1;
					jump      = 1'b1;
				end
				rv_pkg::op_jalr: begin
					alu_op    = rv_pkg::alu_link;
					alu_src   = 1'b1; // Marks the rs1 based target.
					reg_write = 1'b1;
					jump      = 1'b1;
				end
				rv_pkg::op_branch: begin
					alu_op = rv_pkg::alu_branch;
					branch = 1'b1;
				end
				rv_pkg::op_load: begin
					alu_src    = 1'b1;
					reg_write  = 1'b1;
					mem_to_reg = 1'b1;
					mem_read   = 1'b1;
				end
				rv_pkg::op_store: begin
					alu_src   = 1'b1;
					mem_write = 1'b1;
				end
				rv_pkg::op_imm: begin
					alu_op    = rv_pkg::alu_func;
					alu_src   = 1'b1;
					reg_write = 1'b1;
				end
				rv_pkg::op_reg: begin
					alu_op    = rv_pkg::alu_func;
					reg_write = 1'b1;
				end
				default: valid = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  rv_pkg::reg_idx_t        rs1,
	input  rv_pkg::reg_idx_t        rs2,
	input  logic                    wb_en,
	input  rv_pkg::reg_idx_t        wb_rd,
	input  logic [rv_pkg::xlen-1:0] wb_data,
	output logic [rv_pkg::xlen-1:0] rs1_data,
	output logic [rv_pkg::xlen-1:0] rs2_data
);

	logic [rv_pkg::xlen-1:0] regs [1:31]; // x0 is not stored.

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// Same-cycle write is bypassed to the readers.
	always_comb begin
		if (rs1 == '0)
			rs1_data = '0;
		else if (wb_en && wb_rd == rs1)
			rs1_data = wb_data;
		else
			rs1_data = regs[rs1];
		if (rs2 == '0)
			rs2_data = '0;
		else if (wb_en && wb_rd == rs2)
			rs2_data = wb_data;
		else
			rs2_data = regs[rs2];
	end

	a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
		wb_en |-> wb_rd != '0)
		else $error("Writeback enabled towards x0.");

endmodule

`default_nettype wire

// ==== rtl/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    flush,
	input  logic [rv_pkg::xlen-1:0] id_pc,
	input  logic [rv_pkg::xlen-1:0] id_rs1_data,
	input  logic [rv_pkg::xlen-1:0] id_rs2_data,
	input  logic [rv_pkg::xlen-1:0] id_imm,
	input  rv_pkg::reg_idx_t        id_rd,
	input  logic [2:0]              id_func3,
	input  logic                    id_func7_5,
	input  logic                    id_op5,
	input  logic                    id_utype,
	input  rv_pkg::alu_op_t         id_alu_op,
	input  logic                    id_alu_src,
	input  logic                    id_reg_write,
	input  logic                    id_mem_to_reg,
	input  logic                    id_branch,
	input  logic                    id_jump,
	input  logic                    id_mem_read,
	input  logic                    id_mem_write,
	input  logic                    id_valid,
	output logic [rv_pkg::xlen-1:0] ex_pc,
	output logic [rv_pkg::xlen-1:0] ex_rs1_data,
	output logic [rv_pkg::xlen-1:0] ex_rs2_data,
	output logic [rv_pkg::xlen-1:0] ex_imm,
	output rv_pkg::reg_idx_t        ex_rd,
	output logic [2:0]              ex_func3,
	output logic                    ex_func7_5,
	output logic                    ex_op5,
	output logic                    ex_utype,
	output rv_pkg::alu_op_t         ex_alu_op,
	output logic                    ex_alu_src,
	output logic                    ex_reg_write,
	output logic                    ex_mem_to_reg,
	output logic                    ex_branch,
	output logic                    ex_jump,
	output logic                    ex_mem_read,
	output logic                    ex_mem_write,
	output logic                    ex_valid
);

	localparam int bus_w = 4 * rv_pkg::xlen + 19;

	logic [bus_w-1:0] id_bus;
	logic [bus_w-1:0] ex_bus;

	assign id_bus = {id_pc, id_rs1_data, id_rs2_data, id_imm, id_rd, id_func3, id_func7_5,
		id_op5, id_utype, id_alu_src, id_reg_write, id_mem_to_reg, id_branch, id_jump,
		id_mem_read, id_mem_write, id_valid};

	assign {ex_pc, ex_rs1_data, ex_rs2_data, ex_imm, ex_rd, ex_func3, ex_func7_5,
		ex_op5, ex_utype, ex_alu_src, ex_reg_write, ex_mem_to_reg, ex_branch, ex_jump,
		ex_mem_read, ex_mem_write, ex_valid} = ex_bus;

	// Flush turns the incoming instruction into an all-zero bubble.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex_bus    <= '0;
			ex_alu_op <= rv_pkg::alu_add;
		end else begin
			ex_bus    <= flush ? '0 : id_bus;
			ex_alu_op <= flush ? rv_pkg::alu_add : id_alu_op;
		end
	end

	a_ctl_needs_valid: assert property (@(posedge clk) disable iff (reset)
		(ex_reg_write || ex_mem_to_reg || ex_branch || ex_jump || ex_mem_read ||
		ex_mem_write) |-> ex_valid)
		else $error("Control bit set on a bubble.");

	// A redirect comes from a live instruction and leaves a bubble behind it.
	a_flush_squash: assert property (@(posedge clk) disable iff (reset)
		flush |-> ex_valid ##1 !flush)
		else $error("Flush from or after a bubble.");

endmodule

`default_nettype wire

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic [rv_pkg::xlen-1:0] ex_pc,
	input  logic [rv_pkg::xlen-1:0] ex_rs1_data,
	input  logic [rv_pkg::xlen-1:0] ex_rs2_data,
	input  logic [rv_pkg::xlen-1:0] ex_imm,
	input  rv_pkg::reg_idx_t        ex_rd,
	input  logic [2:0]              ex_func3,
	input  logic                    ex_func7_5,
	input  logic                    ex_op5,
	input  logic                    ex_utype,
	input  rv_pkg::alu_op_t         ex_alu_op,
	input  logic                    ex_alu_src,
	input  logic                    ex_reg_write,
	input  logic                    ex_mem_to_reg,
	input  logic                    ex_branch,
	input  logic                    ex_jump,
	input  logic                    ex_mem_read,
	input  logic                    ex_mem_write,
	input  logic                    ex_valid,
	output logic [rv_pkg::xlen-1:0] result,
	output logic                    redirect,
	output logic [rv_pkg::xlen-1:0] target,
	output logic                    wb_en,
	output rv_pkg::reg_idx_t        wb_rd,
	output logic [rv_pkg::xlen-1:0] wb_data,
	output logic [rv_pkg::xlen-1:0] mem_addr,
	output logic [rv_pkg::xlen-1:0] store_data
);

	logic [rv_pkg::xlen-1:0] op_a;
	logic [rv_pkg::xlen-1:0] op_b;
	logic [rv_pkg::xlen-1:0] alu_out;
	logic [rv_pkg::xlen-1:0] jalr_sum;
	logic [5:0]              shamt;
	logic                    taken;

	assign op_a  = ex_utype ? ex_pc : ex_rs1_data; // AUIPC adds to pc.
	assign op_b  = ex_alu_src ? ex_imm : ex_rs2_data;
	assign shamt = op_b[5:0];

	// ~~~~~~~~~~~~~~~~~~~~
	// ALU
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (ex_func3)
			3'b000: alu_out = (ex_op5 && ex_func7_5) ? op_a - op_b : op_a + op_b;
			3'b001: alu_out = op_a << shamt;
			3'b010: alu_out = {{(rv_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			3'b011: alu_out = {{(rv_pkg::xlen-1){1'b0}}, op_a < op_b};
			3'b100: alu_out = op_a ^ op_b;
			3'b101: alu_out = ex_func7_5 ? $signed(op_a) >>> shamt : op_a >> shamt;
			3'b110: alu_out = op_a | op_b;
			default: alu_out = op_a & op_b;
		endcase
	end

	always_comb begin
		case (ex_func3)
			rv_pkg::br_eq:  taken = ex_rs1_data == ex_rs2_data;
			rv_pkg::br_ne:  taken = ex_rs1_data != ex_rs2_data;
			rv_pkg::br_lt:  taken = $signed(ex_rs1_data) < $signed(ex_rs2_data);
			rv_pkg::br_ge:  taken = $signed(ex_rs1_data) >= $signed(ex_rs2_data);
			rv_pkg::br_ltu: taken = ex_rs1_data < ex_rs2_data;
			rv_pkg::br_geu: taken = ex_rs1_data >= ex_rs2_data;
			default:        taken = 1'b0;
		endcase
	end

	always_comb begin
		case (ex_alu_op)
			rv_pkg::alu_add:    result = op_a + op_b;
			rv_pkg::alu_func:   result = alu_out;
			rv_pkg::alu_branch: result = {{(rv_pkg::xlen-1){1'b0}}, taken};
			rv_pkg::alu_lui:    result = ex_imm;
			rv_pkg::alu_auipc:  result = op_a + ex_imm;
			rv_pkg::alu_link:   result = ex_pc + 4;
			default:            result = '0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Control flow and writeback
	// ~~~~~~~~~~~~~~~~~~~~
	assign jalr_sum = ex_rs1_data + ex_imm;
	assign target   = (ex_jump && ex_alu_src) ? {jalr_sum[rv_pkg::xlen-1:1], 1'b0}
		: ex_pc + ex_imm;
	assign redirect = ex_valid && (ex_jump || (ex_branch && taken));

	assign wb_en   = ex_valid && ex_reg_write && !ex_mem_to_reg && ex_rd != '0;
	assign wb_rd   = ex_rd;
	assign wb_data = result;

	assign mem_addr   = ex_rs1_data + ex_imm;
	assign store_data = ex_rs2_data;

	always_comb begin
		a_one_mem_op: assert final (!(ex_mem_read && ex_mem_write))
			else $error("Load and store requested together.");
	end

endmodule

`default_nettype wire

// ==== rtl/decode_execute_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_execute_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [31:0]             instr,
	input  logic [rv_pkg::xlen-1:0] pc,
	input  logic                    instr_valid,
	output logic                    ex_valid,
	output logic [rv_pkg::xlen-1:0] ex_result,
	output rv_pkg::reg_idx_t        ex_rd,
	output logic                    ex_reg_write,
	output logic                    ex_redirect,
	output logic [rv_pkg::xlen-1:0] ex_target,
	output logic                    ex_mem_read,
	output logic                    ex_mem_write,
	output logic [rv_pkg::xlen-1:0] ex_mem_addr,
	output logic [rv_pkg::xlen-1:0] ex_store_data
);

	// ~~~~~~~~~~~~~~~~~~~~
	// Decode side.
	// ~~~~~~~~~~~~~~~~~~~~
	rv_pkg::reg_idx_t        id_rs1, id_rs2, id_rd;
	logic [rv_pkg::xlen-1:0] id_imm, id_rs1_data, id_rs2_data;
	logic [2:0]              id_func3;
	logic                    id_func7_5, id_op5, id_utype, id_alu_src, id_reg_write;
	logic                    id_mem_to_reg, id_branch, id_jump, id_mem_read;
	logic                    id_mem_write, id_valid;
	rv_pkg::alu_op_t         id_alu_op;

	// Execute side.
	logic [rv_pkg::xlen-1:0] ex_pc, ex_rs1_data, ex_rs2_data, ex_imm, wb_data;
	logic [2:0]              ex_func3;
	logic                    ex_func7_5, ex_op5, ex_utype, ex_alu_src, ex_ctl_reg_write;
	logic                    ex_mem_to_reg, ex_branch, ex_jump;
	rv_pkg::alu_op_t         ex_alu_op;
	rv_pkg::reg_idx_t        wb_rd;

	inst_decoder i_inst_decoder (.instr, .instr_valid, .rs1(id_rs1), .rs2(id_rs2),
		.rd(id_rd), .imm(id_imm), .func3(id_func3), .func7_5(id_func7_5), .op5(id_op5),
		.utype(id_utype), .alu_op(id_alu_op), .alu_src(id_alu_src),
		.reg_write(id_reg_write), .mem_to_reg(id_mem_to_reg), .branch(id_branch),
		.jump(id_jump), .mem_read(id_mem_read), .mem_write(id_mem_write), .valid(id_valid));

	reg_file i_reg_file (.clk, .reset, .rs1(id_rs1), .rs2(id_rs2), .wb_en(ex_reg_write),
		.wb_rd, .wb_data, .rs1_data(id_rs1_data), .rs2_data(id_rs2_data));

	// Redirect doubles as the flush.
	id_ex_reg i_id_ex_reg (.clk, .reset, .flush(ex_redirect), .id_pc(pc), .id_rs1_data,
		.id_rs2_data, .id_imm, .id_rd, .id_func3, .id_func7_5, .id_op5, .id_utype,
		.id_alu_op, .id_alu_src, .id_reg_write, .id_mem_to_reg, .id_branch, .id_jump,
		.id_mem_read, .id_mem_write, .id_valid, .ex_pc, .ex_rs1_data, .ex_rs2_data,
		.ex_imm, .ex_rd, .ex_func3, .ex_func7_5, .ex_op5, .ex_utype, .ex_alu_op,
		.ex_alu_src, .ex_reg_write(ex_ctl_reg_write), .ex_mem_to_reg, .ex_branch,
		.ex_jump, .ex_mem_read, .ex_mem_write, .ex_valid);

	ex_stage i_ex_stage (.ex_pc, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rd, .ex_func3,
		.ex_func7_5, .ex_op5, .ex_utype, .ex_alu_op, .ex_alu_src,
		.ex_reg_write(ex_ctl_reg_write), .ex_mem_to_reg, .ex_branch, .ex_jump,
		.ex_mem_read, .ex_mem_write, .ex_valid, .result(ex_result),
		.redirect(ex_redirect), .target(ex_target), .wb_en(ex_reg_write), .wb_rd,
		.wb_data, .mem_addr(ex_mem_addr), .store_data(ex_store_data));

endmodule

`default_nettype wire

// ==== dv/tb_decode_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_execute;

	localparam int n_instr        = 400;
	localparam int timeout_cycles = n_instr * 2 + 50;

	logic                    clk;
	logic                    reset;
	logic [31:0]             instr;
	logic [rv_pkg::xlen-1:0] pc;
	logic                    instr_valid;
	logic                    ex_valid;
	logic [rv_pkg::xlen-1:0] ex_result;
	rv_pkg::reg_idx_t        ex_rd;
	logic                    ex_reg_write;
	logic                    ex_redirect;
	logic [rv_pkg::xlen-1:0] ex_target;
	logic                    ex_mem_read;
	logic                    ex_mem_write;
	logic [rv_pkg::xlen-1:0] ex_mem_addr;
	logic [rv_pkg::xlen-1:0] ex_store_data;

	integer                  seed;
	int                      n_errors = 0;
	int                      n_checked = 0;
	int                      n_sent = 0;
	int                      cycles = 0;
	string                   cur_test;
	logic                    squash = 1'b0; // Next entry follows a redirect.
	logic                    ready;
	logic [rv_pkg::xlen-1:0] next_pc;
	logic [rv_pkg::xlen-1:0] model_regs [32];

	// Instructions presented but not yet checked.
	logic [31:0]             q_instr [$];
	logic [rv_pkg::xlen-1:0] q_pc [$];
	logic [rv_pkg::xlen-1:0] q_imm [$];
	logic                    q_valid [$];

	decode_execute_top i_decode_execute_top (.clk(clk), .reset(reset), .instr(instr),
		.pc(pc), .instr_valid(instr_valid), .ex_valid(ex_valid), .ex_result(ex_result),
		.ex_rd(ex_rd), .ex_reg_write(ex_reg_write), .ex_redirect(ex_redirect),
		.ex_target(ex_target), .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
		.ex_mem_addr(ex_mem_addr), .ex_store_data(ex_store_data));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Compare tasks.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic check_word(input string name, input logic [rv_pkg::xlen-1:0] exp,
		input logic [rv_pkg::xlen-1:0] act);
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", cur_test, name, exp, act);
		end
	endtask

	task automatic check_idx(input string name, input rv_pkg::reg_idx_t exp,
		input rv_pkg::reg_idx_t act);
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s %s: expected x%0d, actual x%0d", cur_test, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s %s: expected %b, actual %b", cur_test, name, exp, act);
		end
	endtask

	task automatic expect_bubble();
		check_bit("ex_valid", 1'b0, ex_valid);
		check_bit("ex_reg_write", 1'b0, ex_reg_write);
		check_bit("ex_redirect", 1'b0, ex_redirect);
		check_bit("ex_mem_read", 1'b0, ex_mem_read);
		check_bit("ex_mem_write", 1'b0, ex_mem_write);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus.
	// ~~~~~~~~~~~~~~~~~~~~
	// Picks the immediate first, then places its bits in the instruction format.
	task automatic make_instr(output logic [31:0] w, output logic [rv_pkg::xlen-1:0] iv);
		logic [31:0]      r;
		logic [31:0]      r2;
		rv_pkg::reg_idx_t rd;
		rv_pkg::reg_idx_t rs1;
		rv_pkg::reg_idx_t rs2;
		logic [2:0]       f3;
		r   = $random(seed);
		r2  = $random(seed);
		rd  = {2'b00, r[6:4]}; // Few registers, so dependencies are frequent.
		rs1 = {2'b00, r[9:7]};
		rs2 = {2'b00, r[12:10]};
		f3  = r[15:13];
		iv  = {{(rv_pkg::xlen-12){r2[11]}}, r2[11:0]};
		case (r[3:0])
			4'd0, 4'd1, 4'd2, 4'd3: begin
				iv = '0;
				w  = {1'b0, r[16] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd,
					rv_pkg::op_reg};
			end
			4'd7, 4'd8: begin
				iv = {{(rv_pkg::xlen-32){r2[31]}}, r2[31:12], 12'b0};
				w  = {r2[31:12], rd, r[3:0] == 4'd7 ? rv_pkg::op_lui : rv_pkg::op_auipc};
			end
			4'd9: begin
				iv = {{(rv_pkg::xlen-21){r2[20]}}, r2[20:1], 1'b0};
				w  = {iv[20], iv[10:1], iv[11], iv[19:12], rd, rv_pkg::op_jal};
			end
			4'd10: w = {iv[11:0], rs1, 3'b000, rd, rv_pkg::op_jalr};
			4'd11, 4'd12: begin
				if (f3[2:1] == 2'b01)
					f3[2:1] = 2'b10; // Skip the two unused codes.
				iv = {{(rv_pkg::xlen-13){r2[12]}}, r2[12:1], 1'b0};
				w  = {iv[12], iv[10:5], rs2, rs1, f3, iv[4:1], iv[11], rv_pkg::op_branch};
			end
			4'd13: w = {iv[11:0], rs1, (f3 == 3'd7) ? 3'd3 : f3, rd, rv_pkg::op_load};
			4'd14: w = {iv[11:5], rs2, rs1, 1'b0, f3[1:0], iv[4:0], rv_pkg::op_store};
			default: begin
				if (f3 == 3'd1)
					iv = {{(rv_pkg::xlen-6){1'b0}}, r2[5:0]};
				if (f3 == 3'd5)
					iv = {{(rv_pkg::xlen-11){1'b0}}, r[16], 4'b0, r2[5:0]}; // srai or srli.
				w = {iv[11:0], rs1, f3, rd, rv_pkg::op_imm};
			end
		endcase
	endtask

	task automatic present_next();
		logic [31:0]             w;
		logic [rv_pkg::xlen-1:0] iv;
		logic                    v;
		if (($random(seed) & 7) == 0) begin
			w = $random(seed); // Junk word behind a low valid.
			instr       <= w;
			instr_valid <= 1'b0;
			iv          = '0;
			v           = 1'b0;
		end else begin
			make_instr(w, iv);
			instr       <= w;
			pc          <= next_pc;
			instr_valid <= 1'b1;
			v           = 1'b1;
		end
		q_instr.push_back(w);
		q_pc.push_back(next_pc);
		q_imm.push_back(iv);
		q_valid.push_back(v);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic model_step(input logic [31:0] w, input logic [rv_pkg::xlen-1:0] pcv,
		input logic [rv_pkg::xlen-1:0] iv, input logic v);
		logic [6:0]              opc;
		logic [2:0]              f3;
		rv_pkg::reg_idx_t        rd;
		logic [rv_pkg::xlen-1:0] a;
		logic [rv_pkg::xlen-1:0] b;
		logic [rv_pkg::xlen-1:0] opb;
		logic [rv_pkg::xlen-1:0] res;
		logic [rv_pkg::xlen-1:0] tgt;
		logic                    taken;
		logic                    is_jump;
		logic                    alu_class;
		opc = w[6:0];
		f3  = w[14:12];
		rd  = w[11:7];
		a   = model_regs[w[19:15]];
		b   = model_regs[w[24:20]];
		opb = (opc == rv_pkg::op_reg) ? b : iv;
		res = '0;
		tgt = pcv + iv;
		taken   = 1'b0;
		is_jump = (opc == rv_pkg::op_jal || opc == rv_pkg::op_jalr);
		alu_class = !(opc == rv_pkg::op_branch || opc == rv_pkg::op_load ||
			opc == rv_pkg::op_store);
		n_checked++;
		cur_test = $sformatf("instr %0d (%h at pc %h)", n_checked, w, pcv);
		if (!v || squash) begin
			expect_bubble(); // Idle cycle or squashed by the redirect before it.
			squash = 1'b0;
		end else begin
			case (opc)
				rv_pkg::op_lui:   res = iv;
				rv_pkg::op_auipc: res = pcv + iv;
				rv_pkg::op_jal:   res = pcv + 4;
				rv_pkg::op_jalr: begin
					res = pcv + 4;
					tgt = (a + iv) & ~64'd1;
				end
				rv_pkg::op_branch: begin
					case (f3)
						rv_pkg::br_eq:  taken = (a == b);
						rv_pkg::br_ne:  taken = (a != b);
						rv_pkg::br_lt:  taken = ($signed(a) < $signed(b));
						rv_pkg::br_ge:  taken = ($signed(a) >= $signed(b));
						rv_pkg::br_ltu: taken = (a < b);
						rv_pkg::br_geu: taken = (a >= b);
						default:        taken = 1'b0;
					endcase
				end
				rv_pkg::op_load, rv_pkg::op_store: res = '0;
				default: begin
					case (f3)
						3'd0: res = (opc == rv_pkg::op_reg && w[30]) ? a - opb : a + opb;
						3'd1: res = a << opb[5:0];
						3'd2: res = ($signed(a) < $signed(opb)) ? 64'd1 : 64'd0;
						3'd3: res = (a < opb) ? 64'd1 : 64'd0;
						3'd4: res = a ^ opb;
						3'd5: begin
							if (w[30])
								res = $signed(a) >>> opb[5:0];
							else
								res = a >> opb[5:0];
						end
						3'd6: res = a | opb;
						default: res = a & opb;
					endcase
				end
			endcase
			check_bit("ex_valid", 1'b1, ex_valid);
			check_bit("ex_reg_write", alu_class && rd != '0, ex_reg_write);
			check_bit("ex_redirect", is_jump || taken, ex_redirect);
			check_bit("ex_mem_read", opc == rv_pkg::op_load, ex_mem_read);
			check_bit("ex_mem_write", opc == rv_pkg::op_store, ex_mem_write);
			if (opc == rv_pkg::op_branch || is_jump)
				check_word("ex_target", tgt, ex_target);
			if (opc == rv_pkg::op_load || opc == rv_pkg::op_store)
				check_word("ex_mem_addr", a + iv, ex_mem_addr);
			if (opc == rv_pkg::op_store)
				check_word("ex_store_data", b, ex_store_data);
			if (alu_class) begin
				check_word("ex_result", res, ex_result);
				check_idx("ex_rd", rd, ex_rd);
				if (rd != '0)
					model_regs[rd] = res;
			end
			squash = is_jump || taken;
		end
	endtask

	initial begin
		seed = 32'hdd596a0f;
		next_pc = 64'h0000_0000_8000_0000;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		reset       <= 1'b1;
		instr       <= '0;
		pc          <= '0;
		instr_valid <= 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		cur_test = "after reset";
		repeat (2) begin
			@(negedge clk);
			expect_bubble();
		end
		while (n_sent < n_instr || q_instr.size() > 0) begin
			@(posedge clk);
			ready = (q_instr.size() > 0); // Entry from the previous edge is now in EX.
			if (n_sent < n_instr) begin
				present_next();
				if (q_valid[$]) begin
					next_pc = next_pc + 4;
					n_sent++;
				end
			end else begin
				instr_valid <= 1'b0;
			end
			@(negedge clk);
			if (ready)
				model_step(q_instr.pop_front(), q_pc.pop_front(), q_imm.pop_front(),
					q_valid.pop_front());
		end
		$display("Checked %0d entries, %0d errors.", n_checked, n_errors);
		if (n_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/rv_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/id_ex_reg.sv
rtl/ex_stage.sv
rtl/decode_execute_top.sv
dv/tb_decode_execute.sv
